// File: testbench/stripe_stimulus.txt
// start_addr length expected_beats final_addr, hex, addresses in beats
// One read request per line, sent in this order
0000 0001 0001 0000
0003 0006 0006 0008
0010 0040 0040 004F
0101 000B 000B 010B
0206 0002 0002 0207
0307 0021 0021 0327
0400 0004 0004 0403
0FFE 0013 0013 1010

// File: sim.f
hdl/stripe_bus_pkg.sv
hdl/stripe_geom_pkg.sv
hdl/stripe_ar_split.sv
hdl/stripe_desc_queue.sv
hdl/stripe_beat_fifo.sv
hdl/stripe_r_reorder.sv
hdl/stripe_read_top.sv
testbench/tb_stripe_read.sv

// File: run_sim.sh
#!/bin/sh
# Build the striped read testbench with Verilator and run it.
# The run passes only if the pass message shows up in the output.

cd "$(dirname "$0")" &&
  verilator --binary --timing -f sim.f --top-module tb_stripe_read &&
  ./obj_dir/Vtb_stripe_read | tee /dev/stderr | grep -q "Everything OK" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: testbench/tb_stripe_read.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the striped read path
// Clock, reset, request driver and two-channel memory responder
// AR stripe checker, read data checker and watchdog
// Requests and expected results come from the stimulus file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_stripe_read
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
();

  localparam int CLK_HALF = 10;
  localparam int MAX_STIM = 16;

  logic                     aclk;
  logic                     aresetn;
  logic [AXI_ADDR_BITS-1:0] req_addr;
  logic [REQ_LEN_BITS-1:0]  req_len;
  logic                     req_valid;
  logic                     req_ready;
  logic [AXI_ADDR_BITS-1:0] m_axi_araddr;
  logic [AXI_LEN_BITS-1:0]  m_axi_arlen;
  logic [CHAN_BITS-1:0]     m_axi_arid;
  logic                     m_axi_arvalid;
  logic                     m_axi_arready;
  logic [AXI_DATA_BITS-1:0] s_axi_rdata;
  logic [CHAN_BITS-1:0]     s_axi_rid;
  logic [AXI_RESP_BITS-1:0] s_axi_rresp;
  logic                     s_axi_rlast;
  logic                     s_axi_rvalid;
  logic                     s_axi_rready;
  logic [AXI_DATA_BITS-1:0] rd_data;
  logic [AXI_RESP_BITS-1:0] rd_resp;
  logic                     rd_last;
  logic                     rd_valid;
  logic                     rd_ready;

  // Start, length, beat count and final address per request
  logic [AXI_ADDR_BITS-1:0] stim_mem [4*MAX_STIM];
  int                       n_req;
  int                       total_beats;
  logic                     stim_loaded;

  // AR side model that walks the stripe rule per request
  int                       ar_req;
  int                       ar_left;
  logic [AXI_ADDR_BITS-1:0] ar_addr;

  // {rlast, beat address} for each beat the memory still owes
  logic [AXI_ADDR_BITS:0]   beat_q0 [$];
  logic [AXI_ADDR_BITS:0]   beat_q1 [$];
  int                       fifo_fill [N_CHAN];
  logic                     r_pending;
  logic                     exp_rready;

  // Client side model
  int                       out_req;
  int                       out_cnt;
  logic [AXI_ADDR_BITS-1:0] out_addr;

  stripe_read_top stripe_read_top_inst (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .req_addr      (req_addr),
    .req_len       (req_len),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_arid    (m_axi_arid),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rid     (s_axi_rid),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rlast   (s_axi_rlast),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_data       (rd_data),
    .rd_resp       (rd_resp),
    .rd_last       (rd_last),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready)
  );

  always #(CLK_HALF) aclk = ~aclk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped at %0d ns: %s", $time, why);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  // AR checker and arready driver
  always begin : ar_model
    int exp_len;
    int chan;
    int k;
    @(posedge aclk);
    if (aresetn && m_axi_arvalid && m_axi_arready) begin
      if (ar_req >= n_req) begin
        abort_run("an AR beat was issued with no request left to serve");
      end
      if (ar_left == 0) begin
        ar_addr = stim_mem[4*ar_req];
        ar_left = int'(stim_mem[4*ar_req+1]);
      end
      // Up to the next stripe boundary or the end of the request
      exp_len = STRIPE_BEATS - int'(ar_addr % STRIPE_BEATS);
      if (exp_len > ar_left) begin
        exp_len = ar_left;
      end
      chan = int'((ar_addr / STRIPE_BEATS) % N_CHAN);
      check_value("m_axi_araddr", 32'(m_axi_araddr), 32'(ar_addr));
      check_value("m_axi_arlen", 32'(m_axi_arlen), 32'(exp_len - 1));
      check_value("m_axi_arid", 32'(m_axi_arid), 32'(chan));
      for (k = 0; k < exp_len; k++) begin
        if (chan == 0) begin
          beat_q0.push_back({(k == exp_len - 1), ar_addr + AXI_ADDR_BITS'(k)});
        end else begin
          beat_q1.push_back({(k == exp_len - 1), ar_addr + AXI_ADDR_BITS'(k)});
        end
      end
      ar_addr = ar_addr + AXI_ADDR_BITS'(exp_len);
      ar_left = ar_left - exp_len;
      if (ar_left == 0) begin
        ar_req++;
      end
    end
    #2;
    m_axi_arready = ($urandom % 4) != 0;
  end

  // Memory responder on the shared R bus
  always begin : r_responder
    int   want_chan;
    logic ok0;
    logic ok1;
    logic [AXI_ADDR_BITS:0] beat;
    @(posedge aclk);
    if (s_axi_rvalid) begin
      // Ready follows the fill of the FIFO named by rid alone
      check_value("s_axi_rready", 32'(s_axi_rready), 32'(exp_rready));
    end
    if (s_axi_rvalid && s_axi_rready) begin
      fifo_fill[s_axi_rid] = fifo_fill[s_axi_rid] + 1;
      r_pending = 1'b0;
    end
    #2;
    // A presented beat stays put until it is taken
    if (!r_pending) begin
      s_axi_rvalid = 1'b0;
      // Channel the client is draining right now
      want_chan = int'(out_addr[STRIPE_LOG +: CHAN_BITS]);
      // Only overrun a full channel FIFO when the client is draining it
      ok0 = (beat_q0.size() > 0) && (fifo_fill[0] < BEAT_FIFO_DEPTH || want_chan == 0);
      ok1 = (beat_q1.size() > 0) && (fifo_fill[1] < BEAT_FIFO_DEPTH || want_chan == 1);
      if ((ok0 || ok1) && ($urandom % 4) != 0) begin
        // Heavily skewed towards channel 0
        if (ok0 && (!ok1 || ($urandom % 8) != 0)) begin
          beat = beat_q0.pop_front();
          s_axi_rid = 1'b0;
        end else begin
          beat = beat_q1.pop_front();
          s_axi_rid = 1'b1;
        end
        s_axi_rdata = {16'h0000, beat[AXI_ADDR_BITS-1:0]};
        s_axi_rlast = beat[AXI_ADDR_BITS];
        s_axi_rresp = '0;
        s_axi_rvalid = 1'b1;
        r_pending = 1'b1;
      end
    end
    exp_rready = (fifo_fill[s_axi_rid] < BEAT_FIFO_DEPTH);
  end

  // Client read data checker and rd_ready driver
  always begin : rd_checker
    int   chan;
    logic exp_last;
    @(posedge aclk);
    if (aresetn && rd_valid && rd_ready) begin
      if (out_req >= n_req) begin
        abort_run("a read data beat came after the last request completed");
      end
      chan = int'(out_addr[STRIPE_LOG +: CHAN_BITS]);
      fifo_fill[chan] = fifo_fill[chan] - 1;
      out_cnt++;
      exp_last = (out_cnt == int'(stim_mem[4*out_req+2]));
      check_value("rd_data", rd_data, {16'h0000, out_addr});
      check_value("rd_resp", 32'(rd_resp), 32'd0);
      check_value("rd_last", 32'(rd_last), 32'(exp_last));
      if (exp_last) begin
        check_value("final beat address", 32'(out_addr), 32'(stim_mem[4*out_req+3]));
        out_req++;
        out_cnt = 0;
        if (out_req < n_req) begin
          out_addr = stim_mem[4*out_req];
        end
      end else begin
        out_addr = out_addr + 1'b1;
      end
    end
    #2;
    rd_ready = ($urandom % 3) != 0;
  end

  // Budget grows with the number of requested beats
  initial begin : watchdog
    wait (stim_loaded);
    repeat (200 * total_beats + 1000) @(posedge aclk);
    abort_run("timed out waiting for read data");
  end

  initial begin : main
    int i;
    void'($urandom(21994));
    aclk = 1'b0;
    aresetn = 1'b0;
    req_addr = '0;
    req_len = '0;
    req_valid = 1'b0;
    m_axi_arready = 1'b0;
    s_axi_rdata = '0;
    s_axi_rid = '0;
    s_axi_rresp = '0;
    s_axi_rlast = 1'b0;
    s_axi_rvalid = 1'b0;
    rd_ready = 1'b0;
    stim_loaded = 1'b0;

    // Zero length marks the end of the list
    for (i = 0; i < 4 * MAX_STIM; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("testbench/stripe_stimulus.txt", stim_mem);
    n_req = 0;
    total_beats = 0;
    while (n_req < MAX_STIM && stim_mem[4*n_req+1] != '0) begin
      total_beats = total_beats + int'(stim_mem[4*n_req+1]);
      n_req++;
    end
    if (n_req == 0) begin
      abort_run("the stimulus file holds no requests");
    end

    ar_req = 0;
    ar_left = 0;
    ar_addr = '0;
    fifo_fill[0] = 0;
    fifo_fill[1] = 0;
    r_pending = 1'b0;
    exp_rready = 1'b1;
    out_req = 0;
    out_cnt = 0;
    out_addr = stim_mem[0];
    stim_loaded = 1'b1;

    repeat (3) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    check_value("req_ready after reset", 32'(req_ready), 32'd0);
    check_value("m_axi_arvalid after reset", 32'(m_axi_arvalid), 32'd0);
    check_value("rd_valid after reset", 32'(rd_valid), 32'd0);

    // Requests go back to back
    for (i = 0; i < n_req; i++) begin
      req_addr = stim_mem[4*i];
      req_len = REQ_LEN_BITS'(stim_mem[4*i+1]);
      req_valid = 1'b1;
      @(posedge aclk);
      while (!req_ready) begin
        @(posedge aclk);
      end
      #2;
    end
    req_valid = 1'b0;

    while (out_req < n_req) begin
      @(posedge aclk);
    end
    // Quiet period to catch stray beats
    repeat (20) @(posedge aclk);
    check_value("requests split into AR beats", 32'(ar_req), 32'(n_req));
    check_value("beats left for channel 0", 32'(beat_q0.size()), 32'd0);
    check_value("beats left for channel 1", 32'(beat_q1.size()), 32'd0);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: hdl/stripe_read_top.sv
//////////////////////////////////////////////////////////////////////
// Striped read path, top level
// Splitter, descriptor queue and reorder stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stripe_read_top
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,

  // Client request
  input  logic [AXI_ADDR_BITS-1:0] req_addr,
  input  logic [REQ_LEN_BITS-1:0]  req_len,
  input  logic                     req_valid,
  output logic                     req_ready,

  // AR to the memory channels
  output logic [AXI_ADDR_BITS-1:0] m_axi_araddr,
  output logic [AXI_LEN_BITS-1:0]  m_axi_arlen,
  output logic [CHAN_BITS-1:0]     m_axi_arid,
  output logic                     m_axi_arvalid,
  input  logic                     m_axi_arready,

  // Shared R bus, rlast is not needed since bursts come from descriptors
  input  logic [AXI_DATA_BITS-1:0] s_axi_rdata,
  input  logic [CHAN_BITS-1:0]     s_axi_rid,
  input  logic [AXI_RESP_BITS-1:0] s_axi_rresp,
  input  logic                     s_axi_rlast,
  input  logic                     s_axi_rvalid,
  output logic                     s_axi_rready,

  // Client read data
  output logic [AXI_DATA_BITS-1:0] rd_data,
  output logic [AXI_RESP_BITS-1:0] rd_resp,
  output logic                     rd_last,
  output logic                     rd_valid,
  input  logic                     rd_ready
);

  // Splitter to queue
  logic [CNT_BITS-1:0]  split_desc_cnt;
  logic [CHAN_BITS-1:0] split_desc_chan;
  logic                 split_desc_last;
  logic                 split_desc_valid;
  logic                 split_desc_ready;

  // Queue to reorder stage
  logic [CNT_BITS-1:0]  q_desc_cnt;
  logic [CHAN_BITS-1:0] q_desc_chan;
  logic                 q_desc_last;
  logic                 q_desc_valid;
  logic                 q_desc_ready;

  stripe_ar_split ar_split_inst (
    .aclk (aclk), .aresetn (aresetn),
    .req_addr (req_addr), .req_len (req_len),
    .req_valid (req_valid), .req_ready (req_ready),
    .m_axi_araddr (m_axi_araddr), .m_axi_arlen (m_axi_arlen),
    .m_axi_arid (m_axi_arid), .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .desc_cnt (split_desc_cnt), .desc_chan (split_desc_chan),
    .desc_last (split_desc_last), .desc_valid (split_desc_valid),
    .desc_ready (split_desc_ready)
  );

  stripe_desc_queue desc_queue_inst (
    .aclk (aclk), .aresetn (aresetn),
    .in_cnt (split_desc_cnt), .in_chan (split_desc_chan),
    .in_last (split_desc_last), .in_valid (split_desc_valid),
    .in_ready (split_desc_ready),
    .out_cnt (q_desc_cnt), .out_chan (q_desc_chan),
    .out_last (q_desc_last), .out_valid (q_desc_valid),
    .out_ready (q_desc_ready)
  );

  stripe_r_reorder r_reorder_inst (
    .aclk (aclk), .aresetn (aresetn),
    .s_axi_rdata (s_axi_rdata), .s_axi_rid (s_axi_rid),
    .s_axi_rresp (s_axi_rresp), .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .desc_cnt (q_desc_cnt), .desc_chan (q_desc_chan),
    .desc_last (q_desc_last), .desc_valid (q_desc_valid),
    .desc_ready (q_desc_ready),
    .rd_data (rd_data), .rd_resp (rd_resp), .rd_last (rd_last),
    .rd_valid (rd_valid), .rd_ready (rd_ready)
  );

endmodule

// File: hdl/stripe_r_reorder.sv
//////////////////////////////////////////////////////////////////////
// Read reorder stage
// Sorts R beats into per-channel FIFOs by rid
// Drains them in descriptor order, rebuilds client bursts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stripe_r_reorder
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,

  // Shared R bus from the channels
  input  logic [AXI_DATA_BITS-1:0] s_axi_rdata,
  input  logic [CHAN_BITS-1:0]     s_axi_rid,
  input  logic [AXI_RESP_BITS-1:0] s_axi_rresp,
  input  logic                     s_axi_rvalid,
  output logic                     s_axi_rready,

  // Descriptors in request order
  input  logic [CNT_BITS-1:0]      desc_cnt,
  input  logic [CHAN_BITS-1:0]     desc_chan,
  input  logic                     desc_last,
  input  logic                     desc_valid,
  output logic                     desc_ready,

  // Client read data
  output logic [AXI_DATA_BITS-1:0] rd_data,
  output logic [AXI_RESP_BITS-1:0] rd_resp,
  output logic                     rd_last,
  output logic                     rd_valid,
  input  logic                     rd_ready
);

  typedef enum logic {ST_IDLE, ST_MUX} state_t;

  state_t               state_q, state_d;
  logic [CNT_BITS-1:0]  cnt_q, cnt_d;
  logic [CHAN_BITS-1:0] chan_q, chan_d;
  logic                 last_q, last_d;

  // Per-channel FIFO links
  logic [N_CHAN-1:0]        fifo_in_valid;
  logic [N_CHAN-1:0]        fifo_in_ready;
  logic [AXI_DATA_BITS-1:0] fifo_out_data [N_CHAN];
  logic [AXI_RESP_BITS-1:0] fifo_out_resp [N_CHAN];
  logic [N_CHAN-1:0]        fifo_out_valid;
  logic [N_CHAN-1:0]        fifo_out_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      cnt_q <= '0;
      chan_q <= '0;
      last_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q <= cnt_d;
      chan_q <= chan_d;
      last_q <= last_d;
    end
  end

  // Output mux follows the loaded descriptor
  assign rd_data = fifo_out_data[chan_q];
  assign rd_resp = fifo_out_resp[chan_q];
  assign rd_last = (cnt_q == '0) && last_q;

  always_comb begin
    state_d = state_q;
    cnt_d = cnt_q;
    chan_d = chan_q;
    last_d = last_q;
    desc_ready = 1'b0;
    rd_valid = 1'b0;
    fifo_out_ready = '0;

    case (state_q)
      ST_IDLE: begin
        // One cycle to load the first descriptor
        desc_ready = 1'b1;
        if (desc_valid) begin
          state_d = ST_MUX;
          cnt_d = desc_cnt;
          chan_d = desc_chan;
          last_d = desc_last;
        end
      end
      ST_MUX: begin
        rd_valid = fifo_out_valid[chan_q];
        fifo_out_ready[chan_q] = rd_ready;
        if (fifo_out_valid[chan_q] && rd_ready) begin
          if (cnt_q == '0) begin
            // Stripe done, chain straight into the next one
            desc_ready = 1'b1;
            if (desc_valid) begin
              cnt_d = desc_cnt;
              chan_d = desc_chan;
              last_d = desc_last;
            end else begin
              state_d = ST_IDLE;
            end
          end else begin
            cnt_d = cnt_q - 1'b1;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Only the FIFO named by rid gates the R bus
  assign s_axi_rready = fifo_in_ready[s_axi_rid];

  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign fifo_in_valid[i] = s_axi_rvalid && (s_axi_rid == CHAN_BITS'(i));

    stripe_beat_fifo beat_fifo_inst (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_data   (s_axi_rdata),
      .in_resp   (s_axi_rresp),
      .in_valid  (fifo_in_valid[i]),
      .in_ready  (fifo_in_ready[i]),
      .out_data  (fifo_out_data[i]),
      .out_resp  (fifo_out_resp[i]),
      .out_valid (fifo_out_valid[i]),
      .out_ready (fifo_out_ready[i])
    );
  end

endmodule

// File: hdl/stripe_beat_fifo.sv
//////////////////////////////////////////////////////////////////////
// Beat FIFO for one memory channel
// Holds returned read data together with its response code
// Full throughput, one write and one read per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stripe_beat_fifo
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,

  // From the shared R bus
  input  logic [AXI_DATA_BITS-1:0] in_data,
  input  logic [AXI_RESP_BITS-1:0] in_resp,
  input  logic                     in_valid,
  output logic                     in_ready,

  // To the reorder mux
  output logic [AXI_DATA_BITS-1:0] out_data,
  output logic [AXI_RESP_BITS-1:0] out_resp,
  output logic                     out_valid,
  input  logic                     out_ready
);

  logic [AXI_DATA_BITS-1:0] data_mem [BEAT_FIFO_DEPTH];
  logic [AXI_RESP_BITS-1:0] resp_mem [BEAT_FIFO_DEPTH];

  logic [BEAT_PTR_BITS-1:0] wr_ptr_q;
  logic [BEAT_PTR_BITS-1:0] rd_ptr_q;
  logic [BEAT_PTR_BITS:0]   count_q;
  logic                     wr_en;
  logic                     rd_en;

  // Full only counts stored beats, a pop in the same cycle
  // does not open a slot
  assign in_ready = (count_q != (BEAT_PTR_BITS+1)'(BEAT_FIFO_DEPTH));
  assign out_valid = (count_q != '0);

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  assign out_data = data_mem[rd_ptr_q];
  assign out_resp = resp_mem[rd_ptr_q];

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Beat storage
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      data_mem[wr_ptr_q] <= in_data;
      resp_mem[wr_ptr_q] <= in_resp;
    end
  end

endmodule

// File: hdl/stripe_desc_queue.sv
//////////////////////////////////////////////////////////////////////
// Descriptor queue
// Circular FIFO between the splitter and the reorder stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stripe_desc_queue
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,

  input  logic [CNT_BITS-1:0]  in_cnt,
  input  logic [CHAN_BITS-1:0] in_chan,
  input  logic                 in_last,
  input  logic                 in_valid,
  output logic                 in_ready,

  output logic [CNT_BITS-1:0]  out_cnt,
  output logic [CHAN_BITS-1:0] out_chan,
  output logic                 out_last,
  output logic                 out_valid,
  input  logic                 out_ready
);

  // Storage, one field per array
  logic [CNT_BITS-1:0]    cnt_mem  [DESC_DEPTH];
  logic [CHAN_BITS-1:0]   chan_mem [DESC_DEPTH];
  logic                   last_mem [DESC_DEPTH];

  logic [DESC_PTR_BITS-1:0] wr_ptr_q;
  logic [DESC_PTR_BITS-1:0] rd_ptr_q;
  logic [DESC_PTR_BITS:0]   count_q;
  logic                     push;
  logic                     pop;

  assign in_ready = (count_q != (DESC_PTR_BITS+1)'(DESC_DEPTH));
  assign out_valid = (count_q != '0);

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  // Head of queue
  assign out_cnt = cnt_mem[rd_ptr_q];
  assign out_chan = chan_mem[rd_ptr_q];
  assign out_last = last_mem[rd_ptr_q];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      cnt_mem[wr_ptr_q] <= in_cnt;
      chan_mem[wr_ptr_q] <= in_chan;
      last_mem[wr_ptr_q] <= in_last;
    end
  end

endmodule

// File: hdl/stripe_ar_split.sv
//////////////////////////////////////////////////////////////////////
// Request splitter
// Cuts a client read into stripes, one AR beat per stripe
// Emits a matching descriptor for the reorder stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stripe_ar_split
  import stripe_bus_pkg::*;
  import stripe_geom_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,

  // Client request
  input  logic [AXI_ADDR_BITS-1:0] req_addr,
  input  logic [REQ_LEN_BITS-1:0]  req_len,
  input  logic                     req_valid,
  output logic                     req_ready,

  // AR towards the memory channels
  output logic [AXI_ADDR_BITS-1:0] m_axi_araddr,
  output logic [AXI_LEN_BITS-1:0]  m_axi_arlen,
  output logic [CHAN_BITS-1:0]     m_axi_arid,
  output logic                     m_axi_arvalid,
  input  logic                     m_axi_arready,

  // Descriptor out
  output logic [CNT_BITS-1:0]      desc_cnt,
  output logic [CHAN_BITS-1:0]     desc_chan,
  output logic                     desc_last,
  output logic                     desc_valid,
  input  logic                     desc_ready
);

  typedef enum logic {ST_IDLE, ST_SPLIT} state_t;

  state_t                   state_q;
  logic                     armed_q;
  logic [AXI_ADDR_BITS-1:0] addr_q;
  logic [REQ_LEN_BITS-1:0]  left_q;
  logic                     ar_done_q;
  logic                     desc_done_q;

  logic [STRIPE_LOG-1:0]    offset;
  logic [REQ_LEN_BITS-1:0]  room;
  logic [REQ_LEN_BITS-1:0]  stripe_len;
  logic [REQ_LEN_BITS-1:0]  stripe_len_m1;
  logic [CHAN_BITS-1:0]     stripe_chan;
  logic                     stripe_last;
  logic                     ar_fire;
  logic                     desc_fire;
  logic                     stripe_done;

  // Beats left until the next stripe boundary
  assign offset = addr_q[STRIPE_LOG-1:0];
  assign room = REQ_LEN_BITS'(STRIPE_BEATS) - REQ_LEN_BITS'(offset);

  // Final stripe once the rest of the request fits
  assign stripe_last = (left_q <= room);
  assign stripe_len = stripe_last ? left_q : room;
  assign stripe_len_m1 = stripe_len - 1'b1;

  // Stripe index mod N_CHAN
  assign stripe_chan = addr_q[STRIPE_LOG +: CHAN_BITS];

  // Low out of reset, ready from the first cycle after it
  assign req_ready = (state_q == ST_IDLE) && armed_q;

  // Each side drops valid once its own handshake is done
  assign m_axi_arvalid = (state_q == ST_SPLIT) && !ar_done_q;
  assign desc_valid = (state_q == ST_SPLIT) && !desc_done_q;

  assign ar_fire = m_axi_arvalid && m_axi_arready;
  assign desc_fire = desc_valid && desc_ready;

  // Advance only when both sides have taken this stripe
  assign stripe_done = (ar_fire || ar_done_q) && (desc_fire || desc_done_q);

  assign m_axi_araddr = addr_q;
  assign m_axi_arlen = AXI_LEN_BITS'(stripe_len_m1);
  assign m_axi_arid = stripe_chan;

  assign desc_cnt = CNT_BITS'(stripe_len_m1);
  assign desc_chan = stripe_chan;
  assign desc_last = stripe_last;

  // FSM and handshake tracking
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      armed_q <= 1'b0;
      ar_done_q <= 1'b0;
      desc_done_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      case (state_q)
        ST_IDLE: begin
          if (req_valid && req_ready) begin
            state_q <= ST_SPLIT;
          end
        end
        ST_SPLIT: begin
          if (stripe_done) begin
            ar_done_q <= 1'b0;
            desc_done_q <= 1'b0;
            if (stripe_last) begin
              state_q <= ST_IDLE;
            end
          end else begin
            // One side went through, hold it off for the other
            if (ar_fire) begin
              ar_done_q <= 1'b1;
            end
            if (desc_fire) begin
              desc_done_q <= 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Current address and beats left
  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) begin
      addr_q <= req_addr;
      left_q <= req_len;
    end else if (state_q == ST_SPLIT && stripe_done) begin
      addr_q <= addr_q + AXI_ADDR_BITS'(stripe_len);
      left_q <= left_q - stripe_len;
    end
  end

endmodule

// File: hdl/stripe_geom_pkg.sv
//////////////////////////////////////////////////////////////////////
// Stripe geometry and request limits
// Descriptor field widths and queue depths
//////////////////////////////////////////////////////////////////////

package stripe_geom_pkg;

  // Beats per stripe, a power of two
  localparam int STRIPE_BEATS = 4;
  localparam int STRIPE_LOG = $clog2(STRIPE_BEATS);

  // Longest client request in beats
  localparam int MAX_REQ_BEATS = 64;

  // req_len runs from 1 up to MAX_REQ_BEATS inclusive
  localparam int REQ_LEN_BITS = $clog2(MAX_REQ_BEATS + 1);

  // Beat counter carried in a descriptor
  localparam int CNT_BITS = 8;

  // Descriptor queue
  localparam int DESC_DEPTH = 8;
  localparam int DESC_PTR_BITS = $clog2(DESC_DEPTH);

  // One beat FIFO per memory channel
  localparam int BEAT_FIFO_DEPTH = 16;
  localparam int BEAT_PTR_BITS = $clog2(BEAT_FIFO_DEPTH);

  // Both depths are powers of two, so the pointers wrap on
  // their own

endpackage

// File: hdl/stripe_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Bus-side constants for the striped read path
// AXI address, data, length and response widths
// Memory channel count and channel id width
//////////////////////////////////////////////////////////////////////

package stripe_bus_pkg;

  // Beat address, counted in beats and not in bytes
  localparam int AXI_ADDR_BITS = 16;

  // One data beat
  localparam int AXI_DATA_BITS = 32;

  // Standard AXI4 burst length field
  localparam int AXI_LEN_BITS = 8;

  // rresp passes through untouched
  localparam int AXI_RESP_BITS = 2;

  // Two DDR channels
  localparam int N_CHAN = 2;

  // Also the width of arid and rid
  localparam int CHAN_BITS = 1;

  // N_CHAN must be a power of two. The channel is then taken
  // straight from the low bits of the stripe index

endpackage
